/* verilog.f */
+incdir+test
hdl/rv_dec_pkg.sv
hdl/rv_i_decoder.sv
hdl/rv_m_decoder.sv
hdl/rv_decoder.sv
hdl/rv_id_ex_pipe.sv
hdl/rv_decode_top.sv
test/tb_decode_top.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the decode testbench for RV32I (0) and RV32E (1)
set -e
cd "$(dirname "$0")"

for variant in 0 1; do
  verilator --binary --assert -Wno-fatal -f verilog.f --top-module tb_decode_top \
    -GTB_RV32=$variant --Mdir obj_dir_$variant
  ./obj_dir_$variant/Vtb_decode_top > sim_$variant.log 2>&1
  cat sim_$variant.log
done

if grep -q "Simulation FAILED" sim_0.log sim_1.log; then
  echo "Decode simulation reported a failure"
  exit 1
fi
if ! grep -q "Simulation PASSED" sim_0.log || ! grep -q "Simulation PASSED" sim_1.log; then
  echo "Decode simulation ended without a result"
  exit 1
fi

/* test/tb_decode_model.svh */
// Reference decode from the RV32I/M tables; M extension always on, needs seed declared by the includer
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

//////////////////////////////////////////////////
// Opcode tables for the generators
//////////////////////////////////////////////////
localparam logic [6:0]  BASE_OPCODES [11] = '{7'h03, 7'h0f, 7'h13, 7'h17, 7'h23, 7'h33,
                                              7'h37, 7'h63, 7'h67, 7'h6f, 7'h73};
localparam logic [11:0] SYS_FUNCT12 [4]   = '{12'h000, 12'h001, 12'h302, 12'h105};

// Expected bundle for one fetch word
function automatic decoder_ctrl_t decode_ref(if_id_pipe_t w, bit rv32e);
  decoder_ctrl_t c;
  logic [6:0]    op;
  logic [2:0]    f3;
  logic [6:0]    f7;
  logic          legal;
  op    = w.instr[6:0];
  f3    = w.instr[14:12];
  f7    = w.instr[31:25];
  legal = 1'b1;
  c     = DECODER_CTRL_ILLEGAL;
  c.illegal_insn = 1'b0;
  if (op == 7'h33 && f7 == 7'h01) begin     // MUL..REMU
    c.rf_we  = 1'b1;
    c.rf_re  = 2'b11;
    c.mul_en = ~f3[2];
    c.div_en = f3[2];
    if (f3[2])
      c.div_operator = div_opcode_e'(f3[1:0]);
    else
      c.mul_operator = mul_opcode_e'(f3[1:0]);
  end else begin
    case (op)
      7'h6f, 7'h67: begin                    // JAL, JALR
        c.alu_en       = 1'b1;
        c.alu_jmp      = 1'b1;
        c.alu_jmpr     = (op == 7'h67);
        c.rf_we        = 1'b1;
        c.rf_re        = {1'b0, op == 7'h67};
        c.op_a_mux_sel = (op == 7'h6f) ? OP_A_CURRPC : OP_A_REGFILE;
        c.op_b_mux_sel = OP_B_IMM;
        c.imm_sel      = (op == 7'h6f) ? IMM_J : IMM_I;
        legal          = (op == 7'h6f) || (f3 == 3'b000);
      end
      7'h63: begin                           // Branches
        c.alu_en  = 1'b1;
        c.alu_bch = 1'b1;
        c.rf_re   = 2'b11;
        c.imm_sel = IMM_B;
        case (f3)
          3'b000:  c.alu_operator = ALU_EQ;
          3'b001:  c.alu_operator = ALU_NE;
          3'b100:  c.alu_operator = ALU_LT;
          3'b101:  c.alu_operator = ALU_GE;
          3'b110:  c.alu_operator = ALU_LTU;
          3'b111:  c.alu_operator = ALU_GEU;
          default: legal = 1'b0;
        endcase
      end
      7'h03: begin                           // LB LH LW LBU LHU
        c.lsu_en       = 1'b1;
        c.rf_we        = 1'b1;
        c.rf_re        = 2'b01;
        c.op_b_mux_sel = OP_B_IMM;
        c.lsu_size     = f3[1:0];
        c.lsu_sext     = ~f3[2];
        legal          = f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
      end
      7'h23: begin                           // SB SH SW
        c.lsu_en       = 1'b1;
        c.lsu_we       = 1'b1;
        c.rf_re        = 2'b11;
        c.op_b_mux_sel = OP_B_IMM;
        c.imm_sel      = IMM_S;
        c.lsu_size     = f3[1:0];
        legal          = f3 inside {3'b000, 3'b001, 3'b010};
      end
      7'h13, 7'h33: begin                    // OP-IMM and OP
        c.alu_en       = 1'b1;
        c.rf_we        = 1'b1;
        c.rf_re        = (op == 7'h33) ? 2'b11 : 2'b01;
        c.op_b_mux_sel = (op == 7'h33) ? OP_B_REGFILE : OP_B_IMM;
        case (f3)
          3'b000:  c.alu_operator = (op == 7'h33 && f7[5]) ? ALU_SUB : ALU_ADD;
          3'b001:  c.alu_operator = ALU_SLL;
          3'b010:  c.alu_operator = ALU_SLT;
          3'b011:  c.alu_operator = ALU_SLTU;
          3'b100:  c.alu_operator = ALU_XOR;
          3'b101:  c.alu_operator = f7[5] ? ALU_SRA : ALU_SRL;
          3'b110:  c.alu_operator = ALU_OR;
          default: c.alu_operator = ALU_AND;
        endcase
        // funct7 only 0x20 for SUB and SRA/SRAI
        if (op == 7'h33 || f3 == 3'b101)
          legal = (f7 == 7'h00) || (f7 == 7'h20 && f3 inside {3'b000, 3'b101});
        else if (f3 == 3'b001)
          legal = (f7 == 7'h00);
      end
      7'h37, 7'h17: begin                    // LUI, AUIPC
        c.alu_en       = 1'b1;
        c.rf_we        = 1'b1;
        c.op_a_mux_sel = (op == 7'h37) ? OP_A_NONE : OP_A_CURRPC;
        c.op_b_mux_sel = OP_B_IMM;
        c.imm_sel      = IMM_U;
      end
      7'h0f: begin
        c.fence  = (f3 == 3'b000);
        c.fencei = (f3 == 3'b001);
        legal    = (f3[2:1] == 2'b00);
      end
      7'h73: begin
        if (f3 == 3'b000) begin
          c.ecall  = (w.instr[31:20] == 12'h000);
          c.ebreak = (w.instr[31:20] == 12'h001);
          c.mret   = (w.instr[31:20] == 12'h302);
          c.wfi    = (w.instr[31:20] == 12'h105);
          legal    = (c.ecall || c.ebreak || c.mret || c.wfi) && (w.instr[19:7] == 13'b0);
        end else begin                       // CSRRW/S/C and immediate forms
          c.csr_en       = 1'b1;
          c.rf_we        = 1'b1;
          c.rf_re        = {1'b0, ~f3[2]};
          c.op_a_mux_sel = f3[2] ? OP_A_IMM : OP_A_REGFILE;
          c.csr_op       = (f3[1] && w.instr[19:15] == 5'd0) ? CSR_OP_READ
                                                               : csr_opcode_e'(f3[1:0]);
          legal          = (f3[1:0] != 2'b00);
        end
      end
      default: legal = 1'b0;
    endcase
  end
  if (!legal || w.illegal_c)
    c = DECODER_CTRL_ILLEGAL;
  // RV32E, bit 4 of any used index is out of range
  if (rv32e && ((c.rf_re[0] && w.instr[19]) || (c.rf_re[1] && w.instr[24]) ||
                (c.rf_we && w.instr[11])))
    c = DECODER_CTRL_ILLEGAL;
  if (w.fetch_err) begin                     // Only the fetch error survives
    c.alu_en       = 1'b0;
    c.alu_bch      = 1'b0;
    c.alu_jmp      = 1'b0;
    c.alu_jmpr     = 1'b0;
    c.mul_en       = 1'b0;
    c.div_en       = 1'b0;
    c.csr_en       = 1'b0;
    c.lsu_en       = 1'b0;
    c.rf_we        = 1'b0;
    c.ecall        = 1'b0;
    c.ebreak       = 1'b0;
    c.mret         = 1'b0;
    c.wfi          = 1'b0;
    c.fence        = 1'b0;
    c.fencei       = 1'b0;
    c.illegal_insn = 1'b0;
  end
  return c;
endfunction

// Mix of base words, M words, funct7 = 1 misuse and garbage
function automatic if_id_pipe_t make_fetch_word();
  if_id_pipe_t w;
  logic [7:0]  kind;
  int          idx;
  w.pc    = $random(seed);
  w.instr = $random(seed);
  kind    = 8'($random(seed));
  idx     = $unsigned($random(seed)) % 11;
  if (kind[7])
    w.instr = w.instr & ~32'h0108_0800;      // rs1, rs2, rd below x16
  case (kind[2:0])
    3'd0, 3'd1, 3'd2, 3'd3: begin
      w.instr[6:0] = BASE_OPCODES[idx];
      if (kind[3])
        w.instr[31:25] = {1'b0, w.instr[30], 5'b0};       // funct7 of 0 or 0x20
      if (w.instr[6:0] == 7'h67)
        w.instr[14:12] = 3'b000;
      if (w.instr[6:0] == 7'h73 && kind[4])
        w.instr[31:7] = {SYS_FUNCT12[kind[6:5]], 13'b0};  // ECALL EBREAK MRET WFI
    end
    3'd4, 3'd5: begin                        // RV32M
      w.instr[6:0]   = 7'h33;
      w.instr[31:25] = 7'h01;
    end
    3'd6: begin
      w.instr[6:0]   = BASE_OPCODES[idx];
      w.instr[31:25] = 7'h01;
    end
    default: ;                               // Raw random word
  endcase
  w.illegal_c = ($random(seed) & 15) == 0;
  w.fetch_err = ($random(seed) & 15) == 0;
  return w;
endfunction

`endif

/* test/tb_decode_top.sv */
// Decode stage testbench; TB_RV32 = 1 selects RV32E, M extension always on, 2000 checked transfers
`timescale 1ns/100ps

module tb_decode_top import rv_dec_pkg::*;
#(
  parameter bit TB_RV32 = 1'b0  // 0 RV32I, 1 RV32E
);

  localparam int CLK_PERIOD  = 8;
  localparam int N_TRANS     = 2000;                      // EX transfers to check
  localparam int WATCHDOG_NS = N_TRANS * 20 * CLK_PERIOD;

  logic        clk;
  logic        arst_n_i;
  logic        if_id_valid_i;
  if_id_pipe_t if_id_pipe_i;
  logic        if_id_ready_o;
  logic        id_ex_valid_o;
  id_ex_pipe_t id_ex_pipe_o;
  logic        ex_ready_i;

  integer      seed;
  int          errors;
  int          n_in;        // Accepted fetch words
  int          n_out;       // Checked EX transfers
  logic        in_xfer;     // Fetch word taken at the coming edge
  logic        prev_stall;  // EX held the item at the last edge
  id_ex_pipe_t held_item;
  id_ex_pipe_t exp_q [$];   // Expected items, oldest first

  `include "tb_decode_model.svh"

  rv_decode_top #(
    .RV32  (rv32_e'(TB_RV32)),
    .M_EXT (M)
  ) DUT (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .if_id_valid_i (if_id_valid_i),
    .if_id_pipe_i  (if_id_pipe_i),
    .if_id_ready_o (if_id_ready_o),
    .id_ex_valid_o (id_ex_valid_o),
    .id_ex_pipe_o  (id_ex_pipe_o),
    .ex_ready_i    (ex_ready_i)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////
  // Compare helpers
  ////////////////////////////////////////////////////
  function automatic logic [31:0] ctrl_group(decoder_ctrl_t c, int g);
    case (g)
      0:       return 32'(c.illegal_insn);
      1:       return 32'({c.alu_en, c.alu_bch, c.alu_jmp, c.alu_jmpr,
                           c.mul_en, c.div_en, c.csr_en, c.lsu_en});
      2:       return 32'({c.rf_we, c.rf_re});
      3:       return 32'(c.alu_operator);
      4:       return 32'({c.mul_operator, c.div_operator, c.csr_op});
      5:       return 32'({c.op_a_mux_sel, c.op_b_mux_sel, c.imm_sel});
      6:       return 32'({c.lsu_we, c.lsu_size, c.lsu_sext});
      default: return 32'({c.ecall, c.ebreak, c.mret, c.wfi, c.fence, c.fencei});
    endcase
  endfunction

  function automatic string group_name(int g);
    case (g)
      0:       return "ctrl.illegal_insn";
      1:       return "ctrl.{alu_en..lsu_en}";
      2:       return "ctrl.{rf_we,rf_re}";
      3:       return "ctrl.alu_operator";
      4:       return "ctrl.{mul_operator,div_operator,csr_op}";
      5:       return "ctrl.{op_a_mux_sel,op_b_mux_sel,imm_sel}";
      6:       return "ctrl.{lsu_we,lsu_size,lsu_sext}";
      default: return "ctrl.{ecall,ebreak,mret,wfi,fence,fencei}";
    endcase
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] got_v);
    if (got_v !== exp_v) begin
      errors++;
      $display("Fail %s expected %h got %h at %0t", name, exp_v, got_v, $time);
    end
  endtask

  // Runs at the falling edge, everything is stable here
  task automatic sample_cycle();
    id_ex_pipe_t exp_item;
    int          g;
    if (prev_stall && (!id_ex_valid_o || id_ex_pipe_o !== held_item)) begin
      errors++;
      $display("ID/EX item changed or dropped under EX stall at %0t", $time);
    end
    // Queue holds exactly the item sitting in ID/EX
    check_val("id_ex_valid_o", 32'(exp_q.size() != 0), 32'(id_ex_valid_o));
    check_val("if_id_ready_o", 32'(exp_q.size() == 0 || ex_ready_i), 32'(if_id_ready_o));
    if (id_ex_valid_o && ex_ready_i && exp_q.size() != 0) begin
      exp_item = exp_q.pop_front();
      check_val("pc", exp_item.pc, id_ex_pipe_o.pc);
      check_val("instr", exp_item.instr, id_ex_pipe_o.instr);
      check_val("fetch_err", 32'(exp_item.fetch_err), 32'(id_ex_pipe_o.fetch_err));
      for (g = 0; g < 8; g++)
        check_val(group_name(g), ctrl_group(exp_item.ctrl, g),
                  ctrl_group(id_ex_pipe_o.ctrl, g));
      n_out++;
    end
    prev_stall = id_ex_valid_o && !ex_ready_i;
    held_item  = id_ex_pipe_o;
    in_xfer    = if_id_valid_i && if_id_ready_o;
    if (in_xfer) begin
      exp_q.push_back('{if_id_pipe_i.pc, if_id_pipe_i.instr,
                        decode_ref(if_id_pipe_i, TB_RV32), if_id_pipe_i.fetch_err});
      n_in++;
    end
  endtask

  ////////////////////////////////////////////////////
  // Stimulus and end of run
  ////////////////////////////////////////////////////
  initial begin
    seed          = 32'h595f_8663;
    clk           = 1'b0;
    arst_n_i      = 1'b0;
    if_id_valid_i = 1'b0;
    if_id_pipe_i  = '0;
    ex_ready_i    = 1'b0;
    errors        = 0;
    n_in          = 0;
    n_out         = 0;
    in_xfer       = 1'b0;
    prev_stall    = 1'b0;
    repeat (5) @(posedge clk);
    #1 arst_n_i = 1'b1;
    check_val("id_ex_valid_o", 32'(1'b0), 32'(id_ex_valid_o));  // Empty after reset
    check_val("if_id_ready_o", 32'(1'b1), 32'(if_id_ready_o));
    while (n_out < N_TRANS) begin
      if (in_xfer || !if_id_valid_i) begin  // Hold the word until it is taken
        if_id_valid_i = (n_in < N_TRANS) && (($random(seed) & 3) != 0);
        if_id_pipe_i  = make_fetch_word();
      end
      ex_ready_i = ($random(seed) & 3) != 0;  // EX stalls about a quarter of cycles
      @(negedge clk);
      sample_cycle();
      @(posedge clk);
      #1;
    end
    $display("Checked %0d transfers, %0d errors", n_out, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Watchdog, 20 cycles per transfer
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout, only %0d of %0d transfers seen", n_out, N_TRANS);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

/* hdl/rv_decode_top.sv */
// Decode stage top; one cycle from accepted fetch word to EX, valid/ready on both sides
`timescale 1ns/100ps

module rv_decode_top import rv_dec_pkg::*;
#(
  parameter rv32_e  RV32  = RV32I, // Base ISA variant
  parameter m_ext_e M_EXT = M      // Multiply/divide present
)
(
  input  logic        clk,
  input  logic        arst_n_i,
  input  logic        if_id_valid_i,  // From fetch
  input  if_id_pipe_t if_id_pipe_i,
  output logic        if_id_ready_o,
  output logic        id_ex_valid_o,  // To execute
  output id_ex_pipe_t id_ex_pipe_o,
  input  logic        ex_ready_i
);

  decoder_ctrl_t dec_ctrl;  // Combinational decode of the waiting word

  rv_decoder #(
    .RV32  (RV32),
    .M_EXT (M_EXT)
  ) decoder_i (
    .if_id_pipe_i   (if_id_pipe_i),
    .decoder_ctrl_o (dec_ctrl)
  );

  rv_id_ex_pipe id_ex_pipe_i (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .if_id_valid_i (if_id_valid_i),
    .if_id_pipe_i  (if_id_pipe_i),
    .dec_ctrl_i    (dec_ctrl),
    .if_id_ready_o (if_id_ready_o),
    .ex_ready_i    (ex_ready_i),
    .id_ex_valid_o (id_ex_valid_o),
    .id_ex_pipe_o  (id_ex_pipe_o)
  );

endmodule

/* hdl/rv_id_ex_pipe.sv */
// ID/EX register; single entry, accepts a new word in the same cycle EX takes the old one
`timescale 1ns/100ps

module rv_id_ex_pipe import rv_dec_pkg::*;
(
  input  logic          clk,
  input  logic          arst_n_i,
  input  logic          if_id_valid_i,  // Fetch word valid
  input  if_id_pipe_t   if_id_pipe_i,
  input  decoder_ctrl_t dec_ctrl_i,     // Decoded bundle for if_id_pipe_i
  output logic          if_id_ready_o,
  input  logic          ex_ready_i,     // EX takes the current item
  output logic          id_ex_valid_o,
  output id_ex_pipe_t   id_ex_pipe_o
);

  logic        id_ex_valid_q;
  id_ex_pipe_t id_ex_pipe_q;
  logic        accept;

  // Free slot, or slot drains this cycle
  assign if_id_ready_o = !id_ex_valid_q || ex_ready_i;
  assign accept        = if_id_valid_i && if_id_ready_o;

  //////////////////////////////////////////////////
  // Valid flag
  //////////////////////////////////////////////////
  always_ff @(posedge clk, negedge arst_n_i) begin
    if (!arst_n_i) begin
      id_ex_valid_q <= 1'b0;
    end else if (if_id_ready_o) begin
      id_ex_valid_q <= if_id_valid_i;  // Refill, or empty when nothing arrives
    end
  end

  // Payload only moves on an accepted transfer
  always_ff @(posedge clk) begin
    if (accept) begin
      id_ex_pipe_q.pc        <= if_id_pipe_i.pc;
      id_ex_pipe_q.instr     <= if_id_pipe_i.instr;
      id_ex_pipe_q.ctrl      <= dec_ctrl_i;
      id_ex_pipe_q.fetch_err <= if_id_pipe_i.fetch_err;
    end
  end

  assign id_ex_valid_o = id_ex_valid_q;
  assign id_ex_pipe_o  = id_ex_pipe_q;

  // Fetch keeps its word steady until ID takes it
  a_fetch_hold : assert property (
    @(posedge clk) disable iff (!arst_n_i)
    (if_id_valid_i && !if_id_ready_o) |=> (if_id_valid_i && $stable(if_id_pipe_i))
  ) else $error("Fetch word changed before ID took it");

endmodule

/* hdl/rv_decoder.sv */
// Merging decoder; RV32E limits GPR indices to 15, fetch_err leaves only the error for EX to trap on
`timescale 1ns/100ps

module rv_decoder import rv_dec_pkg::*;
#(
  parameter rv32_e  RV32  = RV32I, // Base ISA variant
  parameter m_ext_e M_EXT = M      // Multiply/divide present
)
(
  input  if_id_pipe_t   if_id_pipe_i,   // Word from fetch
  output decoder_ctrl_t decoder_ctrl_o  // Merged bundle
);

  decoder_ctrl_t dec_i_raw, dec_m_raw;   // Straight from sub-decoders
  decoder_ctrl_t dec_i_ctrl, dec_m_ctrl; // After register and illegal_c checks
  decoder_ctrl_t dec_mux;
  rf_addr_t      rs1_addr, rs2_addr, rd_addr;
  logic [2:0]    bad_idx;                // {rd, rs2, rs1} out of RV32E range

  assign rs1_addr = if_id_pipe_i.instr[19:15];
  assign rs2_addr = if_id_pipe_i.instr[24:20];
  assign rd_addr  = if_id_pipe_i.instr[11:7];
  assign bad_idx  = (RV32 == RV32E) ? {rd_addr[4], rs2_addr[4], rs1_addr[4]} : 3'b000;

  // Only register fields the format really uses count
  function automatic decoder_ctrl_t check_ctrl(decoder_ctrl_t ctrl, logic [2:0] bad,
                                               logic illegal_c);
    logic bad_reg;
    bad_reg = (ctrl.rf_re[0] && bad[0]) || (ctrl.rf_re[1] && bad[1]) || (ctrl.rf_we && bad[2]);
    return (bad_reg || illegal_c) ? DECODER_CTRL_ILLEGAL : ctrl;
  endfunction

  rv_i_decoder i_decoder_i (
    .instr_i        (if_id_pipe_i.instr),
    .decoder_ctrl_o (dec_i_raw)
  );

  generate
    if (M_EXT == M) begin : gen_m_decoder
      rv_m_decoder m_decoder_i (
        .instr_i        (if_id_pipe_i.instr),
        .decoder_ctrl_o (dec_m_raw)
      );
    end else begin : gen_no_m_decoder
      assign dec_m_raw = DECODER_CTRL_ILLEGAL; // Never matches
    end
  endgenerate

  assign dec_i_ctrl = check_ctrl(dec_i_raw, bad_idx, if_id_pipe_i.illegal_c);
  assign dec_m_ctrl = check_ctrl(dec_m_raw, bad_idx, if_id_pipe_i.illegal_c);

  // M first, then base, else nothing matched
  always_comb begin
    if (!dec_m_ctrl.illegal_insn)      dec_mux = dec_m_ctrl;
    else if (!dec_i_ctrl.illegal_insn) dec_mux = dec_i_ctrl;
    else                               dec_mux = DECODER_CTRL_ILLEGAL;
  end

  //////////////////////////////////////////////////
  // Fetch error suppression
  //////////////////////////////////////////////////
  always_comb begin
    decoder_ctrl_o = dec_mux;
    if (if_id_pipe_i.fetch_err) begin  // Word is garbage, drop all side effects
      decoder_ctrl_o.alu_en       = 1'b0;
      decoder_ctrl_o.alu_bch      = 1'b0;
      decoder_ctrl_o.alu_jmp      = 1'b0;
      decoder_ctrl_o.alu_jmpr     = 1'b0;
      decoder_ctrl_o.mul_en       = 1'b0;
      decoder_ctrl_o.div_en       = 1'b0;
      decoder_ctrl_o.csr_en       = 1'b0;
      decoder_ctrl_o.lsu_en       = 1'b0;
      decoder_ctrl_o.rf_we        = 1'b0;
      decoder_ctrl_o.ecall        = 1'b0;
      decoder_ctrl_o.ebreak       = 1'b0;
      decoder_ctrl_o.mret         = 1'b0;
      decoder_ctrl_o.wfi          = 1'b0;
      decoder_ctrl_o.fence        = 1'b0;
      decoder_ctrl_o.fencei       = 1'b0;
      decoder_ctrl_o.illegal_insn = 1'b0; // Fetch error takes precedence
    end
  end

  // Encoding spaces of the two sub-decoders must not overlap
  always_comb begin
    assert final (dec_i_ctrl.illegal_insn || dec_m_ctrl.illegal_insn)
      else $error("I and M decoders both matched");
  end

endmodule

/* hdl/rv_m_decoder.sv */
// RV32M decoder; only matches OP with funct7 = 1, everything else is the illegal bundle
`timescale 1ns/100ps

module rv_m_decoder import rv_dec_pkg::*;
(
  input  instr_t        instr_i,        // Expanded instruction word
  output decoder_ctrl_t decoder_ctrl_o  // Mul/div bundle or illegal
);

  logic [2:0] funct3;
  logic       m_match;

  assign funct3  = instr_i[14:12];
  assign m_match = (instr_i[6:0] == OPCODE_OP) && (instr_i[31:25] == 7'b000_0001);

  always_comb begin
    decoder_ctrl_o = DECODER_CTRL_ILLEGAL;
    if (m_match) begin
      decoder_ctrl_o.illegal_insn = 1'b0;
      decoder_ctrl_o.rf_re        = 2'b11;      // Both sources
      decoder_ctrl_o.rf_we        = 1'b1;
      if (funct3[2]) begin                      // DIV/DIVU/REM/REMU
        decoder_ctrl_o.div_en       = 1'b1;
        decoder_ctrl_o.div_operator = div_opcode_e'(funct3[1:0]);
      end else begin                            // MUL/MULH/MULHSU/MULHU
        decoder_ctrl_o.mul_en       = 1'b1;
        decoder_ctrl_o.mul_operator = mul_opcode_e'(funct3[1:0]);
      end
    end
  end

endmodule

/* hdl/rv_i_decoder.sv */
// RV32I base decoder; no privilege checks, M-extension words (funct7 = 1) come out illegal
`timescale 1ns/100ps

module rv_i_decoder import rv_dec_pkg::*;
(
  input  instr_t        instr_i,        // Expanded instruction word
  output decoder_ctrl_t decoder_ctrl_o  // Control bundle, illegal_insn on no match
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  rf_addr_t   rs1;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign rs1    = instr_i[19:15];

  always_comb begin
    decoder_ctrl_o              = DECODER_CTRL_ILLEGAL;
    decoder_ctrl_o.illegal_insn = 1'b0; // Assume a match, restored below on bad encodings

    case (opcode)
      //////////////////////////////////////////////////
      // Jumps and branches
      //////////////////////////////////////////////////
      OPCODE_JAL: begin
        decoder_ctrl_o.alu_en       = 1'b1;
        decoder_ctrl_o.alu_jmp      = 1'b1;
        decoder_ctrl_o.rf_we        = 1'b1;         // Link, x0 writes dropped by RF
        decoder_ctrl_o.op_a_mux_sel = OP_A_CURRPC;
        decoder_ctrl_o.op_b_mux_sel = OP_B_IMM;
        decoder_ctrl_o.imm_sel      = IMM_J;
      end
      OPCODE_JALR: begin
        decoder_ctrl_o.alu_en       = 1'b1;
        decoder_ctrl_o.alu_jmp      = 1'b1;
        decoder_ctrl_o.alu_jmpr     = 1'b1;
        decoder_ctrl_o.rf_we        = 1'b1;
        decoder_ctrl_o.rf_re        = 2'b01;        // Base from rs1
        decoder_ctrl_o.op_b_mux_sel = OP_B_IMM;
        if (funct3 != 3'b000) decoder_ctrl_o = DECODER_CTRL_ILLEGAL;
      end
      OPCODE_BRANCH: begin
        decoder_ctrl_o.alu_en  = 1'b1;
        decoder_ctrl_o.alu_bch = 1'b1;
        decoder_ctrl_o.rf_re   = 2'b11;             // Compare rs1 with rs2
        decoder_ctrl_o.imm_sel = IMM_B;             // Target offset
        case (funct3)
          3'b000:  decoder_ctrl_o.alu_operator = ALU_EQ;
          3'b001:  decoder_ctrl_o.alu_operator = ALU_NE;
          3'b100:  decoder_ctrl_o.alu_operator = ALU_LT;
          3'b101:  decoder_ctrl_o.alu_operator = ALU_GE;
          3'b110:  decoder_ctrl_o.alu_operator = ALU_LTU;
          3'b111:  decoder_ctrl_o.alu_operator = ALU_GEU;
          default: decoder_ctrl_o = DECODER_CTRL_ILLEGAL;
        endcase
      end
      //////////////////////////////////////////////////
      // Loads and stores
      //////////////////////////////////////////////////
      OPCODE_LOAD: begin
        decoder_ctrl_o.lsu_en       = 1'b1;
        decoder_ctrl_o.rf_we        = 1'b1;
        decoder_ctrl_o.rf_re        = 2'b01;
        decoder_ctrl_o.op_b_mux_sel = OP_B_IMM;
        decoder_ctrl_o.lsu_size     = funct3[1:0];
        decoder_ctrl_o.lsu_sext     = !funct3[2];   // LBU/LHU zero extend
        if (funct3[1:0] == 2'b11 || funct3 == 3'b110) decoder_ctrl_o = DECODER_CTRL_ILLEGAL;
      end
      OPCODE_STORE: begin
        decoder_ctrl_o.lsu_en       = 1'b1;
        decoder_ctrl_o.lsu_we       = 1'b1;
        decoder_ctrl_o.rf_re        = 2'b11;        // Address base and store data
        decoder_ctrl_o.op_b_mux_sel = OP_B_IMM;
        decoder_ctrl_o.imm_sel      = IMM_S;
        decoder_ctrl_o.lsu_size     = funct3[1:0];
        if (funct3[2] || funct3[1:0] == 2'b11) decoder_ctrl_o = DECODER_CTRL_ILLEGAL;
      end
      //////////////////////////////////////////////////
      // Integer ALU
      //////////////////////////////////////////////////
      OPCODE_OP_IMM: begin
        decoder_ctrl_o.alu_en       = 1'b1;
        decoder_ctrl_o.rf_we        = 1'b1;
        decoder_ctrl_o.rf_re        = 2'b01;
        decoder_ctrl_o.op_b_mux_sel = OP_B_IMM;
        case (funct3)
          3'b000: decoder_ctrl_o.alu_operator = ALU_ADD;
          3'b010: decoder_ctrl_o.alu_operator = ALU_SLT;
          3'b011: decoder_ctrl_o.alu_operator = ALU_SLTU;
          3'b100: decoder_ctrl_o.alu_operator = ALU_XOR;
          3'b110: decoder_ctrl_o.alu_operator = ALU_OR;
          3'b111: decoder_ctrl_o.alu_operator = ALU_AND;
          3'b001: begin
            decoder_ctrl_o.alu_operator = ALU_SLL;
            if (funct7 != 7'b0) decoder_ctrl_o = DECODER_CTRL_ILLEGAL;
          end
          default: begin // 3'b101, bit 30 picks arithmetic shift
            decoder_ctrl_o.alu_operator = funct7[5] ? ALU_SRA : ALU_SRL;
            if ({funct7[6], funct7[4:0]} != 6'b0) decoder_ctrl_o = DECODER_CTRL_ILLEGAL;
          end
        endcase
      end
      OPCODE_OP: begin
        decoder_ctrl_o.alu_en = 1'b1;
        decoder_ctrl_o.rf_we  = 1'b1;
        decoder_ctrl_o.rf_re  = 2'b11;
        case ({funct7[5], funct3})
          4'b0_000: decoder_ctrl_o.alu_operator = ALU_ADD;
          4'b1_000: decoder_ctrl_o.alu_operator = ALU_SUB;
          4'b0_001: decoder_ctrl_o.alu_operator = ALU_SLL;
          4'b0_010: decoder_ctrl_o.alu_operator = ALU_SLT;
          4'b0_011: decoder_ctrl_o.alu_operator = ALU_SLTU;
          4'b0_100: decoder_ctrl_o.alu_operator = ALU_XOR;
          4'b0_101: decoder_ctrl_o.alu_operator = ALU_SRL;
          4'b1_101: decoder_ctrl_o.alu_operator = ALU_SRA;
          4'b0_110: decoder_ctrl_o.alu_operator = ALU_OR;
          4'b0_111: decoder_ctrl_o.alu_operator = ALU_AND;
          default:  decoder_ctrl_o = DECODER_CTRL_ILLEGAL;
        endcase
        // Other funct7 values belong to the M decoder
        if ({funct7[6], funct7[4:0]} != 6'b0) decoder_ctrl_o = DECODER_CTRL_ILLEGAL;
      end
      OPCODE_LUI, OPCODE_AUIPC: begin
        decoder_ctrl_o.alu_en       = 1'b1;
        decoder_ctrl_o.rf_we        = 1'b1;
        decoder_ctrl_o.op_a_mux_sel = (opcode == OPCODE_LUI) ? OP_A_NONE : OP_A_CURRPC;
        decoder_ctrl_o.op_b_mux_sel = OP_B_IMM;
        decoder_ctrl_o.imm_sel      = IMM_U;
      end
      //////////////////////////////////////////////////
      // Fences, system and CSR
      //////////////////////////////////////////////////
      OPCODE_MISC_MEM: begin
        case (funct3)
          3'b000:  decoder_ctrl_o.fence  = 1'b1;
          3'b001:  decoder_ctrl_o.fencei = 1'b1;
          default: decoder_ctrl_o = DECODER_CTRL_ILLEGAL;
        endcase
      end
      OPCODE_SYSTEM: begin
        if (funct3 == 3'b000) begin
          case (instr_i[31:20])
            12'h000: decoder_ctrl_o.ecall  = 1'b1;
            12'h001: decoder_ctrl_o.ebreak = 1'b1;
            12'h302: decoder_ctrl_o.mret   = 1'b1;
            12'h105: decoder_ctrl_o.wfi    = 1'b1;
            default: decoder_ctrl_o = DECODER_CTRL_ILLEGAL;
          endcase
          if ({rs1, instr_i[11:7]} != 10'b0) decoder_ctrl_o = DECODER_CTRL_ILLEGAL;
        end else begin
          decoder_ctrl_o.csr_en       = 1'b1;
          decoder_ctrl_o.rf_we        = 1'b1;       // Old CSR value to rd
          decoder_ctrl_o.rf_re        = {1'b0, !funct3[2]}; // Immediate forms skip rs1
          decoder_ctrl_o.op_a_mux_sel = funct3[2] ? OP_A_IMM : OP_A_REGFILE;
          decoder_ctrl_o.csr_op       = csr_opcode_e'(funct3[1:0]);
          if (funct3[1] && rs1 == 5'd0) decoder_ctrl_o.csr_op = CSR_OP_READ; // Set/clear nothing
          if (funct3[1:0] == 2'b00) decoder_ctrl_o = DECODER_CTRL_ILLEGAL;
        end
      end
      default: decoder_ctrl_o = DECODER_CTRL_ILLEGAL;
    endcase
  end

endmodule

/* hdl/rv_dec_pkg.sv */
// Shared decode types; RV32 only, fetch word arrives expanded, no bit-manip, debug or CLIC fields
package rv_dec_pkg;

  //////////////////////////////////////////////////
  // Configuration and ISA widths
  //////////////////////////////////////////////////

  typedef enum logic {RV32I, RV32E} rv32_e;  // E variant has 16 GPRs
  typedef enum logic {M_NONE, M}    m_ext_e; // Multiply/divide present

  typedef logic [31:0] instr_t;   // Expanded instruction word
  typedef logic [31:0] pc_t;      // Program counter
  typedef logic [4:0]  rf_addr_t; // GPR index

  // Major opcodes, instr[6:0]
  localparam logic [6:0] OPCODE_LOAD     = 7'h03;
  localparam logic [6:0] OPCODE_MISC_MEM = 7'h0f;
  localparam logic [6:0] OPCODE_OP_IMM   = 7'h13;
  localparam logic [6:0] OPCODE_AUIPC    = 7'h17;
  localparam logic [6:0] OPCODE_STORE    = 7'h23;
  localparam logic [6:0] OPCODE_OP       = 7'h33;
  localparam logic [6:0] OPCODE_LUI      = 7'h37;
  localparam logic [6:0] OPCODE_BRANCH   = 7'h63;
  localparam logic [6:0] OPCODE_JALR     = 7'h67;
  localparam logic [6:0] OPCODE_JAL      = 7'h6f;
  localparam logic [6:0] OPCODE_SYSTEM   = 7'h73;

  //////////////////////////////////////////////////
  // Operator and mux select encodings
  //////////////////////////////////////////////////

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,   // Arithmetic and logic
    ALU_SLL, ALU_SRL, ALU_SRA,                    // Shifts
    ALU_SLT, ALU_SLTU,                            // Set less than
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU // Branch compares
  } alu_opcode_e;

  // Low two funct3 bits map straight onto these
  typedef enum logic [1:0] {MUL_MUL, MUL_MULH, MUL_MULHSU, MUL_MULHU} mul_opcode_e;
  typedef enum logic [1:0] {DIV_DIV, DIV_DIVU, DIV_REM, DIV_REMU}    div_opcode_e;
  typedef enum logic [1:0] {CSR_OP_READ, CSR_OP_WRITE, CSR_OP_SET, CSR_OP_CLEAR} csr_opcode_e;

  typedef enum logic [1:0] {OP_A_REGFILE, OP_A_CURRPC, OP_A_IMM, OP_A_NONE} op_a_mux_e;
  typedef enum logic       {OP_B_REGFILE, OP_B_IMM}                         op_b_mux_e;
  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J}             imm_sel_e;

  //////////////////////////////////////////////////
  // Pipeline bundles
  //////////////////////////////////////////////////

  typedef struct packed {
    pc_t    pc;
    instr_t instr;
    logic   illegal_c;  // Compressed expander rejected the halfword
    logic   fetch_err;  // Bus error on fetch
  } if_id_pipe_t;

  typedef struct packed {
    logic        alu_en;
    logic        alu_bch;       // Branch, ALU does the compare
    logic        alu_jmp;       // JAL/JALR, ALU forms link
    logic        alu_jmpr;      // JALR only
    logic        mul_en;
    logic        div_en;
    logic        csr_en;
    logic        lsu_en;
    logic        rf_we;
    logic [1:0]  rf_re;         // [0] rs1, [1] rs2
    alu_opcode_e alu_operator;
    mul_opcode_e mul_operator;
    div_opcode_e div_operator;
    csr_opcode_e csr_op;
    op_a_mux_e   op_a_mux_sel;
    op_b_mux_e   op_b_mux_sel;
    imm_sel_e    imm_sel;
    logic        lsu_we;
    logic [1:0]  lsu_size;      // Byte, half, word
    logic        lsu_sext;
    logic        ecall;
    logic        ebreak;
    logic        mret;
    logic        wfi;
    logic        fence;
    logic        fencei;
    logic        illegal_insn;
  } decoder_ctrl_t;

  typedef struct packed {
    pc_t           pc;
    instr_t        instr;
    decoder_ctrl_t ctrl;
    logic          fetch_err;
  } id_ex_pipe_t;

  // No-match bundle, all enables low
  localparam decoder_ctrl_t DECODER_CTRL_ILLEGAL = '{
    alu_en: 1'b0, alu_bch: 1'b0, alu_jmp: 1'b0, alu_jmpr: 1'b0,
    mul_en: 1'b0, div_en: 1'b0, csr_en: 1'b0, lsu_en: 1'b0,
    rf_we: 1'b0, rf_re: 2'b00,
    alu_operator: ALU_ADD, mul_operator: MUL_MUL,
    div_operator: DIV_DIV, csr_op: CSR_OP_READ,
    op_a_mux_sel: OP_A_REGFILE, op_b_mux_sel: OP_B_REGFILE, imm_sel: IMM_I,
    lsu_we: 1'b0, lsu_size: 2'b00, lsu_sext: 1'b0,
    ecall: 1'b0, ebreak: 1'b0, mret: 1'b0, wfi: 1'b0, fence: 1'b0, fencei: 1'b0,
    illegal_insn: 1'b1
  };

endpackage
